/* Makefile */
# Verilator build and run for the SDRAM controller testbench

VERILATOR ?= verilator
TOP       ?= sdramControllerTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
PASS_MSG  ?= Testbench passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) JOBS=$(JOBS)"
	@echo "  VFLAGS=$(VFLAGS)"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulator output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/clockGen.sv */
// testbench clock generator and power-on reset
`timescale 1ns/1ps

module clockGen (
	output logic Clock,                     // 8 ns period
	output logic Reset_L                    // low across the first two rising edges
);

	localparam int unsigned HalfPeriodNs = 4;

	initial begin
		Clock = 1'b0;
		forever begin
			#HalfPeriodNs Clock = ~Clock;
		end
	end

	initial begin
		Reset_L = 1'b0;
		repeat (2) @(posedge Clock);
		#1 Reset_L = 1'b1;                  // release just after the edge
	end

endmodule

/* dv/sdramControllerTb.sv */
// SDRAM controller testbench with DUT, LFSR reset abort, shadow cycle counter, pin assertions and watchdog
`timescale 1ns/1ps

module sdramControllerTb import sdramPkg::*; ();

	localparam int unsigned ClockPeriodNs  = 8;
	localparam int unsigned DriveSkew      = 1;       // ns after the rising edge
	localparam int unsigned NumRuns        = 3;       // clean, aborted, recovery
	localparam int unsigned RunLimitCycles = 2 * (InitCycles + 3 * RefreshPeriod);
	localparam logic [31:0] LfsrSeed       = 32'h67485bdf;
	localparam logic [31:0] LfsrTaps       = 32'h80200003;  // x^32+x^22+x^2+x+1

	logic                 Clock;
	logic                 porReset_L;                 // from clockGen
	logic                 abortReset_L;               // driven mid-run
	logic                 Reset_L;
	logic                 SDram_CKE_H;
	logic                 SDram_CS_L;
	logic                 SDram_RAS_L;
	logic                 SDram_CAS_L;
	logic                 SDram_WE_L;
	logic [AddrWidth-1:0] SDram_Addr;
	logic                 ResetOut_L;
	sdramCmd_t            pinCmd;                     // pins gathered into one command word
	sdramAddr_u           pinAddr;
	sdramAddr_u           expModeWord;
	int unsigned          cycleCount;                 // edges since reset release
	int unsigned          periodicSeen;               // refreshes after the CPU reset release
	int unsigned          abortAt;
	int unsigned          randomBits;
	logic [31:0]          lfsrState;
	logic                 armed = 1'b0;

	assign Reset_L = porReset_L & abortReset_L;
	assign pinCmd  = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};
	assign pinAddr = SDram_Addr;

	clockGen clkGen (.Clock(Clock), .Reset_L(porReset_L));

	sdramController DUT (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.SDram_CKE_H (SDram_CKE_H),
		.SDram_CS_L  (SDram_CS_L),
		.SDram_RAS_L (SDram_RAS_L),
		.SDram_CAS_L (SDram_CAS_L),
		.SDram_WE_L  (SDram_WE_L),
		.SDram_Addr  (SDram_Addr),
		.ResetOut_L  (ResetOut_L)
	);

	//////////////////////////////////////////////////
	// reference model of the pin sequence
	//////////////////////////////////////////////////

	// n is the edge count after which the pins show the command
	function automatic sdramCmd_t expectedCmd(input int unsigned n);
		int unsigned refFirst;
		int unsigned modeAt;
		int unsigned rise;
		int unsigned phase;
		refFirst = PowerUpCycles + 4;                  // nop, precharge, nop come first
		modeAt   = refFirst + InitRefreshCount * (1 + RefreshNops);
		rise     = modeAt + ModeSetNops + 1;           // first idle nop
		if (n <= PowerUpCycles) return CmdPowerUp;
		if (n == PowerUpCycles + 2) return CmdPrechargeAll;
		if (n >= refFirst && n < modeAt) begin
			if ((n - refFirst) % (1 + RefreshNops) == 0) return CmdAutoRefresh;
			return CmdNop;
		end
		if (n == modeAt) return CmdModeSet;
		// periodic precharge two cycles ahead of its refresh
		if (n >= rise + RefreshInterval + 1) begin
			phase = (n - rise - RefreshInterval - 1) % RefreshPeriod;
			if (phase == 0) return CmdPrechargeAll;
			if (phase == 2) return CmdAutoRefresh;
		end
		return CmdNop;
	endfunction

	function automatic logic expectedResetOut(input int unsigned n);
		return n > InitCycles;                         // high from the first idle nop on
	endfunction

	// burst of one, sequential, CAS 2, standard mode, single-word writes
	function automatic sdramAddr_u buildModeWord();
		sdramAddr_u w;
		w                      = '0;
		w.modeView.burstLength = 3'd0;
		w.modeView.burstType   = 1'b0;
		w.modeView.casLatency  = 3'd2;
		w.modeView.opMode      = 2'd0;
		w.modeView.writeBurst  = 1'b1;
		return w;
	endfunction

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0]) return (s >> 1) ^ LfsrTaps;
		return s >> 1;
	endfunction

	//////////////////////////////////////////////////
	// shadow counters
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			cycleCount   <= 0;
			periodicSeen <= 0;
		end else begin
			cycleCount <= cycleCount + 1;
			if (pinCmd == CmdAutoRefresh && ResetOut_L) begin
				periodicSeen <= periodicSeen + 1;      // pins from the previous edge
			end
		end
	end

	always @(posedge Clock) armed <= 1'b1;             // pins settle on the first edge

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic reportMismatch(input string checkName, input int unsigned expVal,
		input int unsigned actVal);
		$display("** Error: %s expected 0x%0h actual 0x%0h at %0t", checkName, expVal,
			actVal, $time);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	cmdOrder: assert property (@(posedge Clock) armed |-> pinCmd == expectedCmd(cycleCount))
		else reportMismatch("cmdOrder", 32'(expectedCmd($sampled(cycleCount))),
			32'($sampled(pinCmd)));

	resetOutLevel: assert property (@(posedge Clock)
		armed |-> ResetOut_L == expectedResetOut(cycleCount))
		else reportMismatch("resetOutLevel", 32'(expectedResetOut($sampled(cycleCount))),
			32'($sampled(ResetOut_L)));

	resetAddrZero: assert property (@(posedge Clock)
		armed && cycleCount == 0 |-> SDram_Addr == '0)
		else reportMismatch("resetAddrZero", 0, 32'($sampled(SDram_Addr)));

	prechargeAllBanks: assert property (@(posedge Clock)
		armed && pinCmd == CmdPrechargeAll |-> pinAddr.prechargeView.allBanks)
		else reportMismatch("prechargeAllBanks", 1,
			32'($sampled(pinAddr.prechargeView.allBanks)));

	modeWordValue: assert property (@(posedge Clock)
		armed && pinCmd == CmdModeSet |-> pinAddr == expModeWord)
		else reportMismatch("modeWordValue", 32'(expModeWord), 32'($sampled(SDram_Addr)));

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic drawRandom(input int unsigned bits, output int unsigned value);
		value = 0;
		for (int unsigned i = 0; i < bits; i++) begin
			value     = (value << 1) | 32'(lfsrState[0]);  // one step per bit
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	task automatic pulseReset();
		abortReset_L = 1'b0;                           // already skewed past the edge
		repeat (2) @(posedge Clock);
		#DriveSkew abortReset_L = 1'b1;
	endtask

	task automatic runToSecondRefresh();
		do begin
			@(posedge Clock);
			#DriveSkew;
		end while (periodicSeen < 2);
	endtask

	initial begin
		abortReset_L = 1'b1;
		lfsrState    = LfsrSeed;
		expModeWord  = buildModeWord();
		modeWordLayout: assert (expModeWord == 13'h220)
			else reportMismatch("modeWordLayout", 32'h220, 32'(expModeWord));
		runToSecondRefresh();                          // clean run from power-on
		pulseReset();
		drawRandom(12, randomBits);
		abortAt = PowerUpCycles + 1 +
			randomBits % (InitCycles + 2 * RefreshPeriod - PowerUpCycles);
		$display("aborting run at cycle %0d", abortAt);
		do begin
			@(posedge Clock);
			#DriveSkew;
		end while (cycleCount < abortAt);
		pulseReset();                                  // async reset in mid sequence
		runToSecondRefresh();
		$display("Testbench passed");
		$finish;
	end

	// each run gets twice the init length plus three refresh periods
	initial begin
		#(NumRuns * RunLimitCycles * ClockPeriodNs);
		$display("watchdog expired before the second periodic refresh");
		$display("Testbench failed");
		$fatal(1, "simulation timed out");
	end

endmodule

/* logic/commandArbiter.sv */
// command bus arbiter: registered grant, owner command select and SDRAM pin register
`timescale 1ns/1ps

module commandArbiter import sdramPkg::*; (
	input  logic                 Clock,        // 50 MHz controller clock
	input  logic                 Reset_L,      // async, active low
	input  logic                 initReq,      // init sequencer wants the bus
	input  logic                 refReq,       // refresh engine wants the bus
	input  sdramCmd_t            initCmd,
	input  sdramCmd_t            refCmd,
	input  sdramAddr_u           initAddr,
	input  sdramAddr_u           refAddr,
	output logic                 initGrant,    // registered grant to init
	output logic                 refGrant,     // registered grant to refresh
	output logic                 SDram_CKE_H,  // clock enable, active high
	output logic                 SDram_CS_L,   // chip select
	output logic                 SDram_RAS_L,
	output logic                 SDram_CAS_L,
	output logic                 SDram_WE_L,
	output logic [AddrWidth-1:0] SDram_Addr    // row address / mode value
);

	logic       nextInitGrant;
	logic       nextRefGrant;
	sdramCmd_t  busCmd;                        // granted command, before the pins
	sdramAddr_u busAddr;

	//////////////////////////////////////////////////
	// grant register
	//////////////////////////////////////////////////

	// owner keeps the bus while it requests, then init wins a tie
	always_comb begin
		nextInitGrant = 1'b0;
		nextRefGrant  = 1'b0;
		if (initGrant && initReq) begin
			nextInitGrant = 1'b1;
		end else if (refGrant && refReq) begin
			nextRefGrant = 1'b1;
		end else if (initReq) begin
			nextInitGrant = 1'b1;
		end else if (refReq) begin
			nextRefGrant = 1'b1;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			initGrant <= 1'b1;                 // init owns the bus out of reset
			refGrant  <= 1'b0;
		end else begin
			initGrant <= nextInitGrant;
			refGrant  <= nextRefGrant;
		end
	end

	//////////////////////////////////////////////////
	// command select and pin register
	//////////////////////////////////////////////////

	always_comb begin
		busCmd  = CmdNop;                      // nobody granted
		busAddr = '0;
		if (initGrant) begin
			busCmd  = initCmd;
			busAddr = initAddr;
		end else if (refGrant) begin
			busCmd  = refCmd;
			busAddr = refAddr;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= CmdPowerUp;
			SDram_Addr <= '0;
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= busCmd;
			SDram_Addr <= busAddr;             // pins lag the peer by one cycle
		end
	end

	oneOwner: assert property (@(posedge Clock) disable iff (!Reset_L)
		!(initGrant && refGrant));

	// a fresh grant always answers a request from the cycle before
	grantNeedsReq: assert property (@(posedge Clock) disable iff (!Reset_L)
		($rose(initGrant) |-> $past(initReq)) and ($rose(refGrant) |-> $past(refReq)));

endmodule

/* logic/initSequencer.sv */
// init sequencer FSM: power-up wait, precharge-all, refresh burst, mode set, CPU reset release
`timescale 1ns/1ps

module initSequencer import sdramPkg::*; (
	input  logic       Clock,                // 50 MHz controller clock
	input  logic       Reset_L,              // async, active low
	input  logic       initGrant,            // bus is ours this cycle
	output logic       initReq,              // held until the sequence ends
	output logic       initDone,             // level, high once init is over
	output sdramCmd_t  initCmd,              // command offered to the arbiter
	output sdramAddr_u initAddr,             // address word offered with it
	output logic       ResetOut_L            // CPU reset, released after init
);

	logic [InitStateWidth-1:0] state;        // current init step
	logic [TimerWidth-1:0]     timer;        // power-up wait and nop gaps
	logic [TimerWidth-1:0]     refreshLeft;  // refreshes still owed after this one
	logic                      timerZero;

	assign timerZero = (timer == '0);
	assign initDone  = (state == InitIdle);
	assign initReq   = !initDone;            // released for good at the end

	//////////////////////////////////////////////////
	// sequence FSM, advances only while granted
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state       <= InitPowerUp;
			timer       <= PowerUpLoad;      // wait starts with the first edge
			refreshLeft <= RefreshCountLoad;
		end else if (initGrant) begin
			case (state)
				InitPowerUp: begin
					if (timerZero) begin
						state <= InitNop;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				InitNop: begin
					state <= InitPrecharge;      // first nop with CKE high
				end
				InitPrecharge: begin
					state <= InitPrechargeNop;
				end
				InitPrechargeNop: begin
					state <= InitRefresh;
				end
				InitRefresh: begin
					state <= InitRefreshNop;
					timer <= RefreshNopLoad;     // tRC gap
				end
				InitRefreshNop: begin
					if (!timerZero) begin
						timer <= timer - 1'b1;
					end else if (refreshLeft == '0) begin
						state <= InitModeSet;    // burst complete
					end else begin
						state       <= InitRefresh;
						refreshLeft <= refreshLeft - 1'b1;
					end
				end
				InitModeSet: begin
					state <= InitModeNop;
					timer <= ModeNopLoad;        // tMRD gap
				end
				InitModeNop: begin
					if (timerZero) begin
						state <= InitIdle;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				default: begin
					state <= InitIdle;           // parked, refresh engine owns the bus
				end
			endcase
		end
	end

	// one cycle behind initDone, same stage as the pin register
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			ResetOut_L <= 1'b0;
		end else begin
			ResetOut_L <= initDone;
		end
	end

	//////////////////////////////////////////////////
	// command and address decode
	//////////////////////////////////////////////////

	always_comb begin
		initCmd  = CmdNop;                       // every gap state is a nop
		initAddr = '0;
		case (state)
			InitPowerUp: begin
				initCmd = CmdPowerUp;
			end
			InitPrecharge: begin
				initCmd                         = CmdPrechargeAll;
				initAddr.prechargeView.allBanks = 1'b1;
			end
			InitRefresh: begin
				initCmd = CmdAutoRefresh;
			end
			InitModeSet: begin
				initCmd                       = CmdModeSet;
				initAddr.modeView.burstLength = ModeBurstLen1;
				initAddr.modeView.burstType   = ModeSequential;
				initAddr.modeView.casLatency  = ModeCas2;
				initAddr.modeView.opMode      = ModeStandardOp;
				initAddr.modeView.writeBurst  = ModeSingleWrite;
			end
			default: begin
				initCmd = CmdNop;
			end
		endcase
	end

	// init never restarts short of a reset
	doneStaysHigh: assert property (@(posedge Clock) disable iff (!Reset_L)
		initDone |=> initDone);

endmodule

/* logic/refreshEngine.sv */
// refresh engine: interval timer and the periodic precharge-all / auto-refresh sequence
`timescale 1ns/1ps

module refreshEngine import sdramPkg::*; (
	input  logic       Clock,               // 50 MHz controller clock
	input  logic       Reset_L,             // async, active low
	input  logic       initDone,            // init sequencer has finished
	input  logic       refGrant,            // bus is ours this cycle
	output logic       refReq,              // held through the whole sequence
	output sdramCmd_t  refCmd,              // command offered to the arbiter
	output sdramAddr_u refAddr              // address word offered with it
);

	logic [RefStateWidth-1:0] state;
	logic [TimerWidth-1:0]    interval;     // idle cycles left before the next sequence
	logic [TimerWidth-1:0]    seqStep;      // position inside the six commands

	//////////////////////////////////////////////////
	// interval timer and sequence stepping
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state    <= RefIdle;
			interval <= '0;
			seqStep  <= '0;
		end else begin
			case (state)
				RefIdle: begin
					if (initDone) begin
						state    <= RefCount;
						interval <= RefreshLoad;   // first interval starts here
					end
				end
				RefCount: begin
					if (interval == '0) begin
						state   <= RefSeq;         // raise the request
						seqStep <= '0;
					end else begin
						interval <= interval - 1'b1;
					end
				end
				RefSeq: begin
					if (refGrant) begin           // hold the step until granted
						if (seqStep == RefStepLast) begin
							state    <= RefCount;
							interval <= RefreshLoad; // reload on the last nop
						end else begin
							seqStep <= seqStep + 1'b1;
						end
					end
				end
				default: begin
					state <= RefIdle;
				end
			endcase
		end
	end

	assign refReq = (state == RefSeq);

	// precharge at step 0, refresh at step 2, nops elsewhere
	always_comb begin
		refCmd  = CmdNop;
		refAddr = '0;
		if (refReq) begin
			case (seqStep)
				RefStepPrecharge: begin
					refCmd                         = CmdPrechargeAll;
					refAddr.prechargeView.allBanks = 1'b1;
				end
				RefStepRefresh: begin
					refCmd = CmdAutoRefresh;
				end
				default: begin
					refCmd = CmdNop;
				end
			endcase
		end
	end

	// periodic refresh only ever starts after init has let go of the bus
	noRefreshBeforeInit: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(refReq) |-> initDone);

endmodule

/* logic/sdramController.sv */
// SDRAM controller top level: init sequencer and refresh engine sharing the pins via the arbiter
`timescale 1ns/1ps

module sdramController import sdramPkg::*; (
	input  logic                 Clock,        // 50 MHz controller clock
	input  logic                 Reset_L,      // async, active low
	output logic                 SDram_CKE_H,
	output logic                 SDram_CS_L,
	output logic                 SDram_RAS_L,
	output logic                 SDram_CAS_L,
	output logic                 SDram_WE_L,
	output logic [AddrWidth-1:0] SDram_Addr,
	output logic                 ResetOut_L    // CPU held in reset until init ends
);

	logic       initReq;
	logic       initGrant;
	logic       initDone;                     // init finished, refresh may start
	sdramCmd_t  initCmd;
	sdramAddr_u initAddr;
	logic       refReq;
	logic       refGrant;
	sdramCmd_t  refCmd;
	sdramAddr_u refAddr;

	initSequencer initSeq (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.initGrant  (initGrant),
		.initReq    (initReq),
		.initDone   (initDone),
		.initCmd    (initCmd),
		.initAddr   (initAddr),
		.ResetOut_L (ResetOut_L)
	);

	refreshEngine refEng (
		.Clock    (Clock),
		.Reset_L  (Reset_L),
		.initDone (initDone),
		.refGrant (refGrant),
		.refReq   (refReq),
		.refCmd   (refCmd),
		.refAddr  (refAddr)
	);

	commandArbiter cmdArb (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.initReq     (initReq),
		.refReq      (refReq),
		.initCmd     (initCmd),
		.refCmd      (refCmd),
		.initAddr    (initAddr),
		.refAddr     (refAddr),
		.initGrant   (initGrant),
		.refGrant    (refGrant),
		.SDram_CKE_H (SDram_CKE_H),
		.SDram_CS_L  (SDram_CS_L),
		.SDram_RAS_L (SDram_RAS_L),
		.SDram_CAS_L (SDram_CAS_L),
		.SDram_WE_L  (SDram_WE_L),
		.SDram_Addr  (SDram_Addr)
	);

endmodule

/* logic/sdramPkg.sv */
// SDRAM command encodings, address-word union, timing constants and FSM state codes

package sdramPkg;

	//////////////////////////////////////////////////
	// widths and command word
	//////////////////////////////////////////////////

	localparam int unsigned AddrWidth  = 13;            // row address pins A12..A0
	localparam int unsigned TimerWidth = 16;            // all down counters

	// bit order is CKE, CS_L, RAS_L, CAS_L, WE_L
	typedef logic [4:0] sdramCmd_t;

	localparam sdramCmd_t CmdPowerUp      = 5'b00000;   // CKE and CS low while power settles
	localparam sdramCmd_t CmdNop          = 5'b10111;
	localparam sdramCmd_t CmdPrechargeAll = 5'b10010;   // needs A10 high
	localparam sdramCmd_t CmdAutoRefresh  = 5'b10001;
	localparam sdramCmd_t CmdModeSet      = 5'b10000;   // mode value on the address pins

	// one 13-bit address word, read as mode fields or as a precharge word
	typedef union packed {
		struct packed {
			logic [2:0] reserved;                        // A12..A10, kept zero
			logic       writeBurst;                      // A9, 1 = single-word writes
			logic [1:0] opMode;                          // A8..A7, standard operation
			logic [2:0] casLatency;                      // A6..A4
			logic       burstType;                       // A3, 0 = sequential
			logic [2:0] burstLength;                     // A2..A0, 0 = one word
		} modeView;
		struct packed {
			logic [1:0] upper;                           // A12..A11, don't care
			logic       allBanks;                        // A10 selects every bank
			logic [9:0] lower;                           // A9..A0, don't care
		} prechargeView;
	} sdramAddr_u;

	localparam logic [2:0] ModeBurstLen1   = 3'b000;
	localparam logic       ModeSequential  = 1'b0;
	localparam logic [2:0] ModeCas2        = 3'b010;
	localparam logic [1:0] ModeStandardOp  = 2'b00;
	localparam logic       ModeSingleWrite = 1'b1;

	// same fields packed flat, 0x220
	localparam logic [AddrWidth-1:0] ModeWord = {3'b000, ModeSingleWrite, ModeStandardOp,
		ModeCas2, ModeSequential, ModeBurstLen1};

	//////////////////////////////////////////////////
	// timing, in 20 ns clock cycles
	//////////////////////////////////////////////////

	localparam int unsigned PowerUpCycles    = 5000;    // 100 us power-up wait
	localparam int unsigned InitRefreshCount = 10;
	localparam int unsigned RefreshNops      = 3;       // gap after each auto-refresh
	localparam int unsigned ModeSetNops      = 3;
	localparam int unsigned RefreshInterval  = 375;     // 7.5 us of idle nops
	localparam int unsigned RefreshSeqCycles = 6;       // pre, nop, refresh, three nops
	localparam int unsigned RefreshPeriod    = RefreshInterval + RefreshSeqCycles;

	// pin cycles from reset release up to the last mode-set nop
	localparam int unsigned InitCycles = PowerUpCycles + 3 +
		InitRefreshCount * (1 + RefreshNops) + 1 + ModeSetNops;

	// counter preloads, each counts down to zero inclusive
	localparam logic [TimerWidth-1:0] PowerUpLoad      = TimerWidth'(PowerUpCycles - 1);
	localparam logic [TimerWidth-1:0] RefreshNopLoad   = TimerWidth'(RefreshNops - 1);
	localparam logic [TimerWidth-1:0] ModeNopLoad      = TimerWidth'(ModeSetNops - 1);
	localparam logic [TimerWidth-1:0] RefreshCountLoad = TimerWidth'(InitRefreshCount - 1);
	// two idle cycles are spent releasing and regaining the bus grant
	localparam logic [TimerWidth-1:0] RefreshLoad      = TimerWidth'(RefreshInterval - 2);

	//////////////////////////////////////////////////
	// state codes
	//////////////////////////////////////////////////

	localparam int unsigned InitStateWidth = 4;
	localparam logic [InitStateWidth-1:0] InitPowerUp      = 4'd0;
	localparam logic [InitStateWidth-1:0] InitNop          = 4'd1;
	localparam logic [InitStateWidth-1:0] InitPrecharge    = 4'd2;
	localparam logic [InitStateWidth-1:0] InitPrechargeNop = 4'd3;
	localparam logic [InitStateWidth-1:0] InitRefresh      = 4'd4;
	localparam logic [InitStateWidth-1:0] InitRefreshNop   = 4'd5;
	localparam logic [InitStateWidth-1:0] InitModeSet      = 4'd6;
	localparam logic [InitStateWidth-1:0] InitModeNop      = 4'd7;
	localparam logic [InitStateWidth-1:0] InitIdle         = 4'd8;

	localparam int unsigned RefStateWidth = 2;
	localparam logic [RefStateWidth-1:0] RefIdle  = 2'd0;   // waiting for init to finish
	localparam logic [RefStateWidth-1:0] RefCount = 2'd1;   // interval running
	localparam logic [RefStateWidth-1:0] RefSeq   = 2'd2;   // six-command sequence

	localparam logic [TimerWidth-1:0] RefStepPrecharge = TimerWidth'(0);
	localparam logic [TimerWidth-1:0] RefStepRefresh   = TimerWidth'(2);
	localparam logic [TimerWidth-1:0] RefStepLast      = TimerWidth'(RefreshSeqCycles - 1);

endpackage

/* src.f */
logic/sdramPkg.sv
logic/initSequencer.sv
logic/refreshEngine.sv
logic/commandArbiter.sv
logic/sdramController.sv
dv/clockGen.sv
dv/sdramControllerTb.sv
